/* design/sfx_mem_pkg.sv */
package sfx_mem_pkg;

  ////////////////////
  // memory geometry
  ////////////////////

  // byte address as seen by the console and the requesters
  localparam int unsigned ROM_AW = 24;
  // psram word width
  localparam int unsigned ROM_DW = 16;
  // delay preload of the access window
  localparam int unsigned ROM_CYCLE_LEN = 6;

  ////////////////////
  // bus bundles
  ////////////////////

  // console bus, all strobes active low
  typedef struct packed {
    logic [ROM_AW-1:0] addr;
    logic              cpu_clk;
    logic              rd_n;
    logic              wr_n;
    logic              romsel_n;
  } snes_bus_t;

  // gsu bus ownership flags
  typedef struct packed {
    logic go;
    logic ron;
    logic ran;
  } gsu_ctl_t;

  // one request, rrq/wrq are single-cycle strobes
  typedef struct packed {
    logic              rrq;
    logic              wrq;
    logic              word;
    logic [ROM_AW-1:0] addr;
    logic [ROM_DW-1:0] wdata;
  } mem_req_t;

  // psram side, word addressed, strobes active low
  typedef struct packed {
    logic [ROM_AW-2:0] addr;
    logic [ROM_DW-1:0] wdata;
    logic              we_n;
    logic              bhe_n;
    logic              ble_n;
  } rom_bus_t;

  ////////////////////
  // arbiter encodings
  ////////////////////

  // one-hot states
  typedef enum logic [10:0] {
    IDLE       = 11'b000_0000_0001,
    MCU_RD     = 11'b000_0000_0010,
    MCU_RD_END = 11'b000_0000_0100,
    MCU_WR     = 11'b000_0000_1000,
    MCU_WR_END = 11'b000_0001_0000,
    ROM_RD     = 11'b000_0010_0000,
    ROM_RD_END = 11'b000_0100_0000,
    RAM_RD     = 11'b000_1000_0000,
    RAM_RD_END = 11'b001_0000_0000,
    RAM_WR     = 11'b010_0000_0000,
    RAM_WR_END = 11'b100_0000_0000
  } arb_state_e;

  // who owns the psram right now
  typedef enum logic [1:0] {
    NONE    = 2'd0,
    GSU_ROM = 2'd1,
    GSU_RAM = 2'd2,
    MCU     = 2'd3
  } req_src_e;

endpackage

/* design/snes_bus_sync.sv */
module snes_bus_sync #(
  parameter int unsigned DEAD_TIMEOUT = 96000
) (
  input  logic                   CLK2,
  input  logic                   rst_n,
  input  sfx_mem_pkg::snes_bus_t snes,
  output sfx_mem_pkg::snes_bus_t snes_q,
  output logic                   cycle_start,
  output logic                   cycle_end,
  output logic                   dead,
  output logic                   gsu_rst
);

  localparam int unsigned BUS_W = $bits(sfx_mem_pkg::snes_bus_t);
  localparam int unsigned CNT_W = $clog2(DEAD_TIMEOUT + 2);

  // bus at rest: clock low, all strobes released
  localparam sfx_mem_pkg::snes_bus_t BUS_IDLE = '{
    addr:     '0,
    cpu_clk:  1'b0,
    rd_n:     1'b1,
    wr_n:     1'b1,
    romsel_n: 1'b1
  };

  sfx_mem_pkg::snes_bus_t s0, s1, s2;
  sfx_mem_pkg::snes_bus_t filt;
  logic                   clk_prev;
  logic [CNT_W-1:0]       dead_cnt;

  ////////////////////
  // input sampling
  ////////////////////

  // plain shift chain, s0/s1 are the metastability stages
  always_ff @(posedge CLK2) begin
    s0 <= snes;
    s1 <= s0;
    s2 <= s1;
  end

  // glitch filter per bit
  // a new level is taken only when two adjacent samples agree
  always_ff @(posedge CLK2) begin
    if (!rst_n) begin
      filt <= BUS_IDLE;
    end else begin
      for (int i = 0; i < BUS_W; i++) begin
        if (s1[i] == s2[i]) begin
          filt[i] <= s1[i];
        end
      end
    end
  end

  assign snes_q = filt;

  ////////////////////
  // cpu cycle edges
  ////////////////////

  always_ff @(posedge CLK2) begin
    if (!rst_n) begin
      clk_prev <= 1'b0;
    end else begin
      clk_prev <= filt.cpu_clk;
    end
  end

  // rising edge opens the cycle, falling edge closes it
  assign cycle_start = filt.cpu_clk & ~clk_prev;
  assign cycle_end   = ~filt.cpu_clk & clk_prev;

  ////////////////////
  // dead console
  ////////////////////

  // counts low clock time, saturates just past the limit
  always_ff @(posedge CLK2) begin
    if (!rst_n) begin
      dead_cnt <= '0;
    end else if (filt.cpu_clk) begin
      dead_cnt <= '0;
    end else if (dead_cnt <= CNT_W'(DEAD_TIMEOUT)) begin
      dead_cnt <= dead_cnt + 1'b1;
    end
  end

  // console starts out dead, revival gives one reset pulse
  always_ff @(posedge CLK2) begin
    if (!rst_n) begin
      dead    <= 1'b1;
      gsu_rst <= 1'b0;
    end else begin
      gsu_rst <= 1'b0;
      if (filt.cpu_clk) begin
        dead    <= 1'b0;
        gsu_rst <= dead;
      end else if (dead_cnt > CNT_W'(DEAD_TIMEOUT)) begin
        dead <= 1'b1;
      end
    end
  end

endmodule

/* design/mem_request_port.sv */
module mem_request_port #(
  parameter bit WRITABLE = 1'b1
) (
  input  logic                  CLK2,
  input  logic                  rst_n,
  input  sfx_mem_pkg::mem_req_t req,
  input  logic                  done,
  output logic                  pend_rd,
  output logic                  pend_wr,
  output sfx_mem_pkg::mem_req_t held,
  output logic                  rdy
);

  logic wr_ok;

  // read-only ports never see a write strobe
  assign wr_ok = req.wrq & WRITABLE;

  ////////////////////
  // pending flags
  ////////////////////

  // read wins if both strobes show up together
  always_ff @(posedge CLK2) begin
    if (!rst_n) begin
      pend_rd <= 1'b0;
      pend_wr <= 1'b0;
      rdy     <= 1'b1;
    end else if (req.rrq) begin
      pend_rd <= 1'b1;
      rdy     <= 1'b0;
    end else if (wr_ok) begin
      pend_wr <= 1'b1;
      rdy     <= 1'b0;
    end else if (done) begin
      // served, hand the port back to the requester
      pend_rd <= 1'b0;
      pend_wr <= 1'b0;
      rdy     <= 1'b1;
    end
  end

  ////////////////////
  // captured request
  ////////////////////

  // address, size and data stay put until the next request
  always_ff @(posedge CLK2) begin
    if (req.rrq | wr_ok) begin
      held <= req;
    end
  end

endmodule

/* design/mem_arbiter.sv */
module mem_arbiter (
  input  logic                              CLK2,
  input  logic                              rst_n,
  input  logic                              cycle_start,
  input  logic                              cycle_end,
  input  logic                              dead,
  input  logic                              revive,
  input  logic                              rom_hit,
  input  sfx_mem_pkg::gsu_ctl_t             gsu,
  input  logic                              rom_pend_rd,
  input  logic                              rom_pend_wr,
  input  logic                              ram_pend_rd,
  input  logic                              ram_pend_wr,
  input  logic                              mcu_pend_rd,
  input  logic                              mcu_pend_wr,
  input  logic [sfx_mem_pkg::ROM_DW-1:0]    rom_rdata,
  input  logic                              addr0,
  output sfx_mem_pkg::req_src_e             grant,
  output logic                              wr_phase,
  output logic                              done_rom,
  output logic                              done_ram,
  output logic                              done_mcu,
  output logic                              ron_q,
  output logic [sfx_mem_pkg::ROM_DW-1:0]    gsu_rom_rdata,
  output logic [sfx_mem_pkg::ROM_DW-1:0]    gsu_ram_rdata,
  output logic [7:0]                        mcu_rdata
);

  sfx_mem_pkg::arb_state_e          state;
  logic [3:0]                       delay;
  logic                             ran_q;
  logic                             free_strobe;
  logic                             free_slot;
  logic                             rom_pend;
  logic [sfx_mem_pkg::ROM_DW-1:0]   word_rd;
  logic [7:0]                       byte_rd;

  ////////////////////
  // free slot
  ////////////////////

  // flags only change at cycle end so the console never sees half a vector
  always_ff @(posedge CLK2) begin
    if (!rst_n) begin
      ron_q <= 1'b0;
      ran_q <= 1'b0;
    end else if (cycle_end) begin
      ron_q <= gsu.ron & gsu.go;
      ran_q <= gsu.ran & gsu.go;
    end
  end

  // gsu owns both buses: every cycle is free
  // otherwise one slot after cycle start if the console is not using rom
  always_ff @(posedge CLK2) begin
    if (!rst_n) begin
      free_strobe <= 1'b0;
    end else if (ron_q & ran_q) begin
      free_strobe <= 1'b1;
    end else if (cycle_start) begin
      free_strobe <= ~rom_hit | ron_q;
    end else begin
      free_strobe <= 1'b0;
    end
  end

  assign free_slot = cycle_end | free_strobe;

  // rom port is read only, anything pending there is a read
  assign rom_pend = rom_pend_rd | rom_pend_wr;

  ////////////////////
  // state machine
  ////////////////////

  always_ff @(posedge CLK2) begin
    if (!rst_n) begin
      state <= sfx_mem_pkg::IDLE;
    end else if (revive) begin
      // abort, the pending flag makes it retry
      state <= sfx_mem_pkg::IDLE;
    end else begin
      unique case (state)
        sfx_mem_pkg::IDLE: begin
          if (free_slot | dead) begin
            // fixed priority
            if (rom_pend)         state <= sfx_mem_pkg::ROM_RD;
            else if (ram_pend_rd) state <= sfx_mem_pkg::RAM_RD;
            else if (ram_pend_wr) state <= sfx_mem_pkg::RAM_WR;
            else if (mcu_pend_rd) state <= sfx_mem_pkg::MCU_RD;
            else if (mcu_pend_wr) state <= sfx_mem_pkg::MCU_WR;
          end
        end
        sfx_mem_pkg::ROM_RD: if (delay == '0) state <= sfx_mem_pkg::ROM_RD_END;
        sfx_mem_pkg::RAM_RD: if (delay == '0) state <= sfx_mem_pkg::RAM_RD_END;
        sfx_mem_pkg::RAM_WR: if (delay == '0) state <= sfx_mem_pkg::RAM_WR_END;
        sfx_mem_pkg::MCU_RD: if (delay == '0) state <= sfx_mem_pkg::MCU_RD_END;
        sfx_mem_pkg::MCU_WR: if (delay == '0) state <= sfx_mem_pkg::MCU_WR_END;
        // end states last one cycle
        default: state <= sfx_mem_pkg::IDLE;
      endcase
    end
  end

  // window is ROM_CYCLE_LEN+1 cycles, preload while idle
  always_ff @(posedge CLK2) begin
    if (!rst_n) begin
      delay <= '0;
    end else if (state == sfx_mem_pkg::IDLE) begin
      delay <= 4'(sfx_mem_pkg::ROM_CYCLE_LEN);
    end else if (grant != sfx_mem_pkg::NONE) begin
      delay <= delay - 1'b1;
    end
  end

  // bus owner, only during the access window
  always_comb begin
    unique case (state)
      sfx_mem_pkg::ROM_RD:                       grant = sfx_mem_pkg::GSU_ROM;
      sfx_mem_pkg::RAM_RD, sfx_mem_pkg::RAM_WR:  grant = sfx_mem_pkg::GSU_RAM;
      sfx_mem_pkg::MCU_RD, sfx_mem_pkg::MCU_WR:  grant = sfx_mem_pkg::MCU;
      default:                                   grant = sfx_mem_pkg::NONE;
    endcase
  end

  assign wr_phase = (state == sfx_mem_pkg::RAM_WR) | (state == sfx_mem_pkg::MCU_WR);

  assign done_rom = (state == sfx_mem_pkg::ROM_RD_END);
  assign done_ram = (state == sfx_mem_pkg::RAM_RD_END) | (state == sfx_mem_pkg::RAM_WR_END);
  assign done_mcu = (state == sfx_mem_pkg::MCU_RD_END) | (state == sfx_mem_pkg::MCU_WR_END);

  ////////////////////
  // read data
  ////////////////////

  // odd address: as stored, even address: bytes swapped
  assign word_rd = addr0 ? rom_rdata : {rom_rdata[7:0], rom_rdata[15:8]};
  assign byte_rd = addr0 ? rom_rdata[7:0] : rom_rdata[15:8];

  // sampled every window cycle, last sample wins
  always_ff @(posedge CLK2) begin
    unique case (state)
      sfx_mem_pkg::ROM_RD: gsu_rom_rdata <= word_rd;
      sfx_mem_pkg::RAM_RD: gsu_ram_rdata <= word_rd;
      sfx_mem_pkg::MCU_RD: mcu_rdata     <= byte_rd;
      default: begin
      end
    endcase
  end

endmodule

/* design/rom_bus_mux.sv */
module rom_bus_mux (
  input  sfx_mem_pkg::req_src_e           grant,
  input  logic                            wr_phase,
  input  sfx_mem_pkg::mem_req_t           gsu_rom,
  input  sfx_mem_pkg::mem_req_t           gsu_ram,
  input  sfx_mem_pkg::mem_req_t           mcu,
  input  sfx_mem_pkg::snes_bus_t          snes_q,
  input  logic                            ron_q,
  input  logic [sfx_mem_pkg::ROM_DW-1:0]  rom_rdata,
  output logic                            addr0,
  output sfx_mem_pkg::rom_bus_t           rom,
  output logic [7:0]                      snes_rdata
);

  logic [sfx_mem_pkg::ROM_AW-1:0] sel_addr;
  logic [sfx_mem_pkg::ROM_DW-1:0] sel_wdata;
  logic                           sel_word;
  logic [7:0]                     vector;

  ////////////////////
  // source select
  ////////////////////

  // console gets the bus whenever nobody is granted
  always_comb begin
    unique case (grant)
      sfx_mem_pkg::GSU_ROM: begin
        sel_addr  = gsu_rom.addr;
        sel_word  = gsu_rom.word;
        sel_wdata = gsu_rom.wdata;
      end
      sfx_mem_pkg::GSU_RAM: begin
        sel_addr  = gsu_ram.addr;
        sel_word  = gsu_ram.word;
        sel_wdata = gsu_ram.wdata;
      end
      sfx_mem_pkg::MCU: begin
        sel_addr  = mcu.addr;
        sel_word  = mcu.word;
        // mcu is byte wide
        sel_wdata = {8'h00, mcu.wdata[7:0]};
      end
      default: begin
        sel_addr  = snes_q.addr;
        sel_word  = 1'b0;
        sel_wdata = '0;
      end
    endcase
  end

  assign addr0 = sel_addr[0];

  ////////////////////
  // psram side
  ////////////////////

  always_comb begin
    rom.addr  = sel_addr[sfx_mem_pkg::ROM_AW-1:1];
    // low byte to the low lane on odd addresses, high lane on even
    rom.wdata = addr0 ? sel_wdata : {sel_wdata[7:0], sel_wdata[15:8]};
    rom.we_n  = ~wr_phase;
    // word access forces both lanes
    rom.bhe_n = addr0 & ~sel_word;
    rom.ble_n = ~addr0 & ~sel_word;
  end

  ////////////////////
  // console read data
  ////////////////////

  // gsu owns rom: console only sees the interrupt vector pattern
  always_comb begin
    if (snes_q.addr[0]) begin
      vector = 8'h01;
    end else begin
      vector = {5'b00000,
                snes_q.addr[3] & snes_q.addr[1],
                snes_q.addr[2] & (snes_q.addr[3] ~^ snes_q.addr[1]),
                1'b0};
    end
  end

  assign snes_rdata = (ron_q & ~snes_q.romsel_n) ? vector
                    : addr0 ? rom_rdata[7:0] : rom_rdata[15:8];

endmodule

/* design/sfx_mem_ctrl.sv */
module sfx_mem_ctrl #(
  parameter int unsigned DEAD_TIMEOUT = 96000
) (
  input  logic                            CLK2,
  input  logic                            rst_n,
  input  sfx_mem_pkg::snes_bus_t          snes,
  input  sfx_mem_pkg::gsu_ctl_t           gsu,
  input  sfx_mem_pkg::mem_req_t           gsu_rom_req,
  input  sfx_mem_pkg::mem_req_t           gsu_ram_req,
  input  sfx_mem_pkg::mem_req_t           mcu_req,
  input  logic [sfx_mem_pkg::ROM_DW-1:0]  rom_rdata,
  output logic                            gsu_rom_rdy,
  output logic                            gsu_ram_rdy,
  output logic                            mcu_rdy,
  output logic [sfx_mem_pkg::ROM_DW-1:0]  gsu_rom_rdata,
  output logic [sfx_mem_pkg::ROM_DW-1:0]  gsu_ram_rdata,
  output logic [7:0]                      mcu_rdata,
  output sfx_mem_pkg::rom_bus_t           rom,
  output logic [7:0]                      snes_rdata,
  output logic                            gsu_rst
);

  sfx_mem_pkg::snes_bus_t snes_q;
  logic                   cycle_start;
  logic                   cycle_end;
  logic                   dead;

  // captured requests and their pending flags
  sfx_mem_pkg::mem_req_t  rom_held, ram_held, mcu_held;
  logic                   rom_pend_rd, rom_pend_wr;
  logic                   ram_pend_rd, ram_pend_wr;
  logic                   mcu_pend_rd, mcu_pend_wr;
  logic                   done_rom, done_ram, done_mcu;

  sfx_mem_pkg::req_src_e  grant;
  logic                   wr_phase;
  logic                   addr0;
  logic                   ron_q;

  ////////////////////
  // console side
  ////////////////////

  snes_bus_sync #(.DEAD_TIMEOUT(DEAD_TIMEOUT)) i_snes_bus_sync (
    .CLK2, .rst_n, .snes, .snes_q, .cycle_start, .cycle_end, .dead, .gsu_rst
  );

  ////////////////////
  // request ports
  ////////////////////

  mem_request_port #(.WRITABLE(1'b0)) i_rom_port (
    .CLK2, .rst_n, .req(gsu_rom_req), .done(done_rom),
    .pend_rd(rom_pend_rd), .pend_wr(rom_pend_wr), .held(rom_held), .rdy(gsu_rom_rdy)
  );

  mem_request_port #(.WRITABLE(1'b1)) i_ram_port (
    .CLK2, .rst_n, .req(gsu_ram_req), .done(done_ram),
    .pend_rd(ram_pend_rd), .pend_wr(ram_pend_wr), .held(ram_held), .rdy(gsu_ram_rdy)
  );

  mem_request_port #(.WRITABLE(1'b1)) i_mcu_port (
    .CLK2, .rst_n, .req(mcu_req), .done(done_mcu),
    .pend_rd(mcu_pend_rd), .pend_wr(mcu_pend_wr), .held(mcu_held), .rdy(mcu_rdy)
  );

  ////////////////////
  // arbitration and psram
  ////////////////////

  // no mapper, romsel alone marks a rom hit
  mem_arbiter i_mem_arbiter (
    .CLK2, .rst_n, .cycle_start, .cycle_end, .dead,
    .revive(gsu_rst), .rom_hit(~snes_q.romsel_n), .gsu,
    .rom_pend_rd, .rom_pend_wr, .ram_pend_rd, .ram_pend_wr, .mcu_pend_rd, .mcu_pend_wr,
    .rom_rdata, .addr0, .grant, .wr_phase, .done_rom, .done_ram, .done_mcu, .ron_q,
    .gsu_rom_rdata, .gsu_ram_rdata, .mcu_rdata
  );

  rom_bus_mux i_rom_bus_mux (
    .grant, .wr_phase, .gsu_rom(rom_held), .gsu_ram(ram_held), .mcu(mcu_held),
    .snes_q, .ron_q, .rom_rdata, .addr0, .rom, .snes_rdata
  );

endmodule

/* verif/tb_clock.sv */
module tb_clock #(
  parameter int PERIOD       = 20,
  parameter int RESET_CYCLES = 10
) (
  output logic CLK2,
  output logic rst_n
);

  // free running, first rising edge after half a period
  initial begin
    CLK2 = 1'b0;
    forever #(PERIOD / 2) CLK2 = ~CLK2;
  end

  // synchronous reset, let go on a falling edge
  initial begin
    rst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge CLK2);
    @(negedge CLK2);
    rst_n = 1'b1;
  end

endmodule

/* verif/tb_sfx_mem_ctrl.sv */
module tb_sfx_mem_ctrl;

  localparam int ROM_PORT  = 0;
  localparam int RAM_PORT  = 1;
  localparam int MCU_PORT  = 2;
  localparam int MEM_WORDS = 4096;
  // console clock half period in CLK2 cycles
  // long enough for the glitch filter
  localparam int CONSOLE_HALF = 8;
  // sync chain plus filter with some margin
  localparam int SYNC_SETTLE = 6;
  // free slot wait then ROM_CYCLE_LEN+1 window cycles and one END cycle
  localparam int READY_TIMEOUT = 2 * CONSOLE_HALF + 4 * (sfx_mem_pkg::ROM_CYCLE_LEN + 2);
  // 40 + 34 + 3 + 4 transactions over the tests
  localparam int NUM_TXN = 81;
  localparam int WATCHDOG_CYCLES = NUM_TXN * 64 + 2000;

  // what the checker expects when a ready rises
  typedef struct packed {
    logic        is_rd;
    logic [15:0] data;
  } exp_t;

  logic                           CLK2;
  logic                           rst_n;
  sfx_mem_pkg::snes_bus_t         snes;
  sfx_mem_pkg::gsu_ctl_t          gsu;
  sfx_mem_pkg::mem_req_t          gsu_rom_req, gsu_ram_req, mcu_req;
  logic [sfx_mem_pkg::ROM_DW-1:0] rom_rdata;
  logic                           gsu_rom_rdy, gsu_ram_rdy, mcu_rdy;
  logic [sfx_mem_pkg::ROM_DW-1:0] gsu_rom_rdata, gsu_ram_rdata;
  logic [7:0]                     mcu_rdata;
  sfx_mem_pkg::rom_bus_t          rom;
  logic [7:0]                     snes_rdata;
  logic                           gsu_rst;

  logic        console_run = 1'b0;
  logic [15:0] mem [0:MEM_WORDS-1];
  logic [15:0] shadow [0:MEM_WORDS-1];
  logic [11:0] mem_idx;
  exp_t        exp_rom[$], exp_ram[$], exp_mcu[$];
  logic [2:0]  rdy_prev = 3'b111;
  int          rise_cyc [3];
  int          rst_pulses = 0;
  int          cyc = 0;

  tb_clock #(.PERIOD(20), .RESET_CYCLES(10)) i_tb_clock (.CLK2, .rst_n);

  sfx_mem_ctrl #(.DEAD_TIMEOUT(200)) i_sfx_mem_ctrl (
    .CLK2, .rst_n, .snes, .gsu, .gsu_rom_req, .gsu_ram_req, .mcu_req, .rom_rdata,
    .gsu_rom_rdy, .gsu_ram_rdy, .mcu_rdy, .gsu_rom_rdata, .gsu_ram_rdata, .mcu_rdata,
    .rom, .snes_rdata, .gsu_rst
  );

  ////////////////////
  // psram model
  ////////////////////

  // only the low word address bits are decoded
  assign mem_idx   = rom.addr[11:0];
  assign rom_rdata = mem[mem_idx];

  always @(posedge CLK2) begin
    if (!rom.we_n) begin
      if (!rom.ble_n) begin
        mem[mem_idx][7:0] <= rom.wdata[7:0];
      end
      if (!rom.bhe_n) begin
        mem[mem_idx][15:8] <= rom.wdata[15:8];
      end
    end
  end

  always @(posedge CLK2) begin
    cyc <= cyc + 1;
  end

  ////////////////////
  // reference model
  ////////////////////

  function automatic logic [15:0] fill_word(input int unsigned idx);
    return 16'((idx * 32'h0000_9e37) ^ (idx >> 3) ^ 32'h0000_a5c3);
  endfunction

  // odd address keeps the stored order and even address swaps the bytes
  function automatic logic [15:0] ref_read(input logic [23:0] addr, input logic word);
    logic [15:0] w;
    w = shadow[addr[12:1]];
    if (word) begin
      return addr[0] ? w : {w[7:0], w[15:8]};
    end
    return {8'h00, addr[0] ? w[7:0] : w[15:8]};
  endfunction

  task automatic shadow_write(input logic [23:0] addr, input logic word,
                              input logic [15:0] wdata);
    logic [11:0] idx;
    idx = addr[12:1];
    if (word) begin
      shadow[idx] = addr[0] ? wdata : {wdata[7:0], wdata[15:8]};
    end else if (addr[0]) begin
      // odd byte goes to the low lane
      shadow[idx][7:0] = wdata[7:0];
    end else begin
      shadow[idx][15:8] = wdata[7:0];
    end
  endtask

  // vector seen by the console while the gsu owns rom
  function automatic logic [7:0] vector_byte(input logic [23:0] addr);
    logic [7:0] v;
    v = 8'h00;
    if (addr[0]) begin
      v = 8'h01;
    end else begin
      v[2] = addr[3] & addr[1];
      v[1] = addr[2] & (addr[3] == addr[1]);
    end
    return v;
  endfunction

  ////////////////////
  // checking
  ////////////////////

  task automatic stop_run;
    $display("Simulation finished: FAIL");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic check(input string name, input logic [31:0] actual,
                       input logic [31:0] expected);
    if (actual !== expected) begin
      $display("FAIL time=%0t signal=%s actual=0x%0h expected=0x%0h",
               $time, name, actual, expected);
      stop_run();
    end
  endtask

  function automatic string port_name(input int port);
    case (port)
      ROM_PORT: return "gsu_rom";
      RAM_PORT: return "gsu_ram";
      default:  return "mcu";
    endcase
  endfunction

  function automatic logic rdy_of(input int port);
    case (port)
      ROM_PORT: return gsu_rom_rdy;
      RAM_PORT: return gsu_ram_rdy;
      default:  return mcu_rdy;
    endcase
  endfunction

  // a rising ready closes the oldest outstanding request of that port
  task automatic compare_port(input int port, input logic rdy_now, input logic [15:0] rdata);
    exp_t e;
    int   depth;
    logic rose;
    rose = rdy_now && !rdy_prev[port];
    rdy_prev[port] = rdy_now;
    if (rose) begin
      rise_cyc[port] = cyc;
      case (port)
        ROM_PORT: depth = exp_rom.size();
        RAM_PORT: depth = exp_ram.size();
        default:  depth = exp_mcu.size();
      endcase
      if (depth == 0) begin
        $display("%s ready rose while no request was outstanding", port_name(port));
        stop_run();
      end else begin
        case (port)
          ROM_PORT: e = exp_rom.pop_front();
          RAM_PORT: e = exp_ram.pop_front();
          default:  e = exp_mcu.pop_front();
        endcase
        if (e.is_rd) begin
          check({port_name(port), "_rdata"}, 32'(rdata), 32'(e.data));
        end
      end
    end
  endtask

  // outputs are stable at the falling edge
  always @(negedge CLK2) begin : compare
    if (rst_n) begin
      if (gsu_rst) begin
        rst_pulses++;
      end
      compare_port(ROM_PORT, gsu_rom_rdy, gsu_rom_rdata);
      compare_port(RAM_PORT, gsu_ram_rdy, gsu_ram_rdata);
      compare_port(MCU_PORT, mcu_rdy, {8'h00, mcu_rdata});
    end
  end

  ////////////////////
  // stimulus helpers
  ////////////////////

  task automatic wait_ready(input int port);
    int n;
    n = 0;
    while (!rdy_of(port)) begin
      @(negedge CLK2);
      n++;
      if (n > READY_TIMEOUT) begin
        $display("%s ready did not rise within %0d cycles", port_name(port), READY_TIMEOUT);
        stop_run();
      end
    end
  endtask

  // drives one strobe and records what the checker should see
  task automatic issue_req(input int port, input logic rd, input logic word,
                           input logic [23:0] addr, input logic [15:0] wdata);
    sfx_mem_pkg::mem_req_t r;
    exp_t                  e;
    r.rrq   = rd;
    r.wrq   = ~rd;
    r.word  = word;
    r.addr  = addr;
    r.wdata = wdata;
    e.is_rd = rd;
    e.data  = rd ? ref_read(addr, word) : 16'h0000;
    if (!rd) begin
      shadow_write(addr, word, wdata);
    end
    case (port)
      ROM_PORT: begin
        gsu_rom_req = r;
        exp_rom.push_back(e);
      end
      RAM_PORT: begin
        gsu_ram_req = r;
        exp_ram.push_back(e);
      end
      default: begin
        mcu_req = r;
        exp_mcu.push_back(e);
      end
    endcase
  endtask

  task automatic clear_reqs;
    gsu_rom_req.rrq = 1'b0;
    gsu_rom_req.wrq = 1'b0;
    gsu_ram_req.rrq = 1'b0;
    gsu_ram_req.wrq = 1'b0;
    mcu_req.rrq     = 1'b0;
    mcu_req.wrq     = 1'b0;
  endtask

  // one full handshake
  // ready must drop right after the strobe
  task automatic run_txn(input int port, input logic rd, input logic word,
                         input logic [23:0] addr, input logic [15:0] wdata);
    wait_ready(port);
    issue_req(port, rd, word, addr, wdata);
    @(negedge CLK2);
    clear_reqs();
    check({port_name(port), "_rdy"}, 32'(rdy_of(port)), 32'd0);
    wait_ready(port);
  endtask

  task automatic settle;
    repeat (SYNC_SETTLE) @(negedge CLK2);
  endtask

  ////////////////////
  // watchdog
  ////////////////////

  initial begin : watchdog
    repeat (WATCHDOG_CYCLES) @(posedge CLK2);
    $display("watchdog expired after %0d cycles, the tests did not finish", WATCHDOG_CYCLES);
    stop_run();
  end

  // console clock toggles only once enabled
  initial begin : console_clock
    forever begin
      repeat (CONSOLE_HALF) @(negedge CLK2);
      if (console_run) begin
        snes.cpu_clk = ~snes.cpu_clk;
      end
    end
  end

  initial begin
    for (int i = 0; i < MEM_WORDS; i++) begin
      mem[i] <= fill_word(i);
      shadow[i] = fill_word(i);
    end
  end

  ////////////////////
  // test sequence
  ////////////////////

  initial begin : main
    logic [23:0] a;
    logic [15:0] w;
    int          n;
    void'($urandom(32'h8c75));
    snes.addr     = '0;
    snes.cpu_clk  = 1'b0;
    snes.rd_n     = 1'b1;
    snes.wr_n     = 1'b1;
    snes.romsel_n = 1'b1;
    gsu           = '0;
    gsu_rom_req   = '0;
    gsu_ram_req   = '0;
    mcu_req       = '0;
    wait (rst_n === 1'b1);
    @(negedge CLK2);

    // out of reset
    check("gsu_rom_rdy", 32'(gsu_rom_rdy), 32'd1);
    check("gsu_ram_rdy", 32'(gsu_ram_rdy), 32'd1);
    check("mcu_rdy", 32'(mcu_rdy), 32'd1);
    check("rom.we_n", 32'(rom.we_n), 32'd1);
    check("gsu_rst", 32'(gsu_rst), 32'd0);

    // mcu byte write then read back while the console is dead
    for (int i = 0; i < 20; i++) begin
      a = 24'($urandom() & 32'h1fff);
      run_txn(MCU_PORT, 1'b0, 1'b0, a, {8'h00, 8'($urandom())});
      run_txn(MCU_PORT, 1'b1, 1'b0, a, 16'h0000);
    end

    // gsu ram words at alternating parity, each also read at the other parity
    for (int i = 0; i < 6; i++) begin
      a = {11'h000, 12'($urandom()), 1'(i)};
      w = 16'($urandom());
      run_txn(RAM_PORT, 1'b0, 1'b1, a, w);
      run_txn(RAM_PORT, 1'b1, 1'b1, a, 16'h0000);
      run_txn(RAM_PORT, 1'b1, 1'b1, a ^ 24'h1, 16'h0000);
    end

    // mcu fills both bytes and gsu rom reads the word back
    for (int i = 0; i < 4; i++) begin
      a = {11'h000, 12'($urandom()), 1'b0};
      run_txn(MCU_PORT, 1'b0, 1'b0, a, {8'h00, 8'($urandom())});
      run_txn(MCU_PORT, 1'b0, 1'b0, a | 24'h1, {8'h00, 8'($urandom())});
      run_txn(ROM_PORT, 1'b1, 1'b1, a | 24'h1, 16'h0000);
      run_txn(ROM_PORT, 1'b1, 1'b1, a, 16'h0000);
    end

    // three requests in one cycle
    issue_req(ROM_PORT, 1'b1, 1'b1, 24'h000101, 16'h0000);
    issue_req(RAM_PORT, 1'b1, 1'b1, 24'h000202, 16'h0000);
    issue_req(MCU_PORT, 1'b1, 1'b0, 24'h000303, 16'h0000);
    @(negedge CLK2);
    clear_reqs();
    wait_ready(ROM_PORT);
    wait_ready(RAM_PORT);
    wait_ready(MCU_PORT);
    @(negedge CLK2);
    check("gsu_rom_rdy_before_gsu_ram_rdy",
          32'(rise_cyc[ROM_PORT] < rise_cyc[RAM_PORT]), 32'd1);
    check("gsu_ram_rdy_before_mcu_rdy",
          32'(rise_cyc[RAM_PORT] < rise_cyc[MCU_PORT]), 32'd1);

    // console comes alive
    console_run = 1'b1;
    n = 0;
    while (rst_pulses == 0) begin
      @(negedge CLK2);
      n++;
      if (n > 4 * CONSOLE_HALF) begin
        $display("gsu_rst never pulsed after the console clock started");
        stop_run();
      end
    end
    repeat (4) @(negedge CLK2);
    check("gsu_rst_pulse_cycles", 32'(rst_pulses), 32'd1);

    // requests still go through between console cycles
    a = {11'h000, 12'($urandom()), 1'b1};
    run_txn(MCU_PORT, 1'b0, 1'b0, a, {8'h00, 8'($urandom())});
    run_txn(MCU_PORT, 1'b1, 1'b0, a, 16'h0000);
    a = {11'h000, 12'($urandom()), 1'b0};
    run_txn(RAM_PORT, 1'b0, 1'b1, a, 16'($urandom()));
    run_txn(RAM_PORT, 1'b1, 1'b1, a, 16'h0000);

    // plain console rom read
    snes.romsel_n = 1'b0;
    snes.rd_n     = 1'b0;
    snes.addr     = 24'h000a35;
    settle();
    check("snes_rdata", 32'(snes_rdata), 32'(ref_read(snes.addr, 1'b0)));
    snes.addr = 24'h000a34;
    settle();
    check("snes_rdata", 32'(snes_rdata), 32'(ref_read(snes.addr, 1'b0)));

    // gsu takes rom and the flags land at the next cycle end
    gsu.go  = 1'b1;
    gsu.ron = 1'b1;
    @(negedge snes.cpu_clk);
    settle();
    check("snes_rdata", 32'(snes_rdata), 32'(vector_byte(snes.addr)));
    for (int i = 0; i < 16; i++) begin
      snes.addr = 24'h00ffe0 + 24'(i);
      settle();
      check("snes_rdata", 32'(snes_rdata), 32'(vector_byte(snes.addr)));
    end

    @(negedge CLK2);
    check("outstanding_requests", 32'(exp_rom.size() + exp_ram.size() + exp_mcu.size()), 32'd0);
    check("gsu_rst_pulse_cycles", 32'(rst_pulses), 32'd1);
    $display("Simulation finished: PASS");
    $finish;
  end

endmodule

/* vlog.f */
design/sfx_mem_pkg.sv
design/snes_bus_sync.sv
design/mem_request_port.sv
design/mem_arbiter.sv
design/rom_bus_mux.sv
design/sfx_mem_ctrl.sv
verif/tb_clock.sv
verif/tb_sfx_mem_ctrl.sv

/* Makefile */
# Verilator flow for the memory arbitration core

VERILATOR ?= verilator
TOP       ?= tb_sfx_mem_ctrl
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing -Wno-fatal
PASS_MSG  ?= Simulation finished: PASS

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

# the log decides pass or fail
sim: build
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
